// File: tb.f
+incdir+.
stq_pkg.sv
stq_operand_match.sv
stq_entry.sv
stq_issue_select.sv
stq_top.sv
tb_stq.sv

// File: Bender.yml
package:
  name: stq_queue

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - stq_pkg.sv
      - stq_operand_match.sv
      - stq_entry.sv
      - stq_issue_select.sv
      - stq_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_stq.sv

// File: tb_stq.sv
`timescale 1ns/10ps
`include "stq_settings.svh"

module tb_stq;

  import stq_pkg::*;

  localparam int WAIT_LIMIT = 500;
  localparam int TAB_SIZE   = 16;

  typedef struct packed {
    stq_cmt_id_t cmt_id;
    stq_rnid_t   rs1;
    stq_rnid_t   rs2;
    logic [3:0]  tab_sel;
    stq_data_t   wb_data;
    stq_index_t  slot;
  } store_rec_t;

  typedef struct packed {
    stq_addr_t addr;
    stq_data_t data;
  } exp_write_t;

  logic        clk;
  logic        reset_n;
  logic        disp_valid;
  stq_cmt_id_t disp_cmt_id;
  stq_rnid_t   disp_rs1_rnid;
  logic        disp_rs1_ready;
  stq_rnid_t   disp_rs2_rnid;
  logic        disp_rs2_ready;
  logic        disp_full;
  logic        phy_wr_valid [`STQ_PHY_WR_NUM];
  stq_rnid_t   phy_wr_rnid  [`STQ_PHY_WR_NUM];
  stq_data_t   phy_wr_data  [`STQ_PHY_WR_NUM];
  logic        issue_valid;
  stq_index_t  issue_index;
  stq_rnid_t   issue_rs1_rnid;
  logic        ex1_valid;
  stq_index_t  ex1_index;
  logic        ex1_hazard;
  stq_addr_t   ex1_paddr;
  logic        tlb_resolve;
  logic        done_valid;
  stq_cmt_id_t done_cmt_id;
  logic        commit_valid;
  stq_cmt_id_t commit_cmt_id;
  logic        commit_flush;
  logic        l1d_wr_valid;
  stq_addr_t   l1d_wr_paddr;
  stq_data_t   l1d_wr_data;
  logic        l1d_wr_conflict;

  stq_addr_t   addr_tab    [TAB_SIZE];
  store_rec_t  slot_rec    [`STQ_ENTRY_NUM];  // store living in each entry
  bit          rs1_woken   [`STQ_ENTRY_NUM];
  bit          rs2_woken   [`STQ_ENTRY_NUM];
  int          issue_count [`STQ_ENTRY_NUM];
  bit          done_seen   [1 << `STQ_CMT_ID_W];
  store_rec_t  exp_q       [$];
  stq_cmt_id_t commit_q    [$];

  stq_index_t  in_slot        = '0;
  int          next_rnid      = 0;
  int          next_cmt       = 0;
  int          errors         = 0;
  int          checks         = 0;
  int          tests          = 0;
  int          commits_open   = 0;
  int          conflict_count = 0;
  int          hazard_hits    = 0;
  int          hazard_slot    = 0;
  stq_cmt_id_t flush_cmt_id   = '0;
  bit          auto_commit    = 1'b1;
  bit          conflict_en    = 1'b0;
  bit          hazard_armed   = 1'b0;
  bit          flush_armed    = 1'b0;

  stq_top dut_i (
    .i_clk             (clk),
    .i_reset_n         (reset_n),
    .i_disp_valid      (disp_valid),
    .i_disp_cmt_id     (disp_cmt_id),
    .i_disp_rs1_rnid   (disp_rs1_rnid),
    .i_disp_rs1_ready  (disp_rs1_ready),
    .i_disp_rs2_rnid   (disp_rs2_rnid),
    .i_disp_rs2_ready  (disp_rs2_ready),
    .o_disp_full       (disp_full),
    .i_phy_wr_valid    (phy_wr_valid),
    .i_phy_wr_rnid     (phy_wr_rnid),
    .i_phy_wr_data     (phy_wr_data),
    .o_issue_valid     (issue_valid),
    .o_issue_index     (issue_index),
    .o_issue_rs1_rnid  (issue_rs1_rnid),
    .i_ex1_valid       (ex1_valid),
    .i_ex1_index       (ex1_index),
    .i_ex1_hazard      (ex1_hazard),
    .i_ex1_paddr       (ex1_paddr),
    .i_tlb_resolve     (tlb_resolve),
    .o_done_valid      (done_valid),
    .o_done_cmt_id     (done_cmt_id),
    .i_commit_valid    (commit_valid),
    .i_commit_cmt_id   (commit_cmt_id),
    .i_commit_flush    (commit_flush),
    .o_l1d_wr_valid    (l1d_wr_valid),
    .o_l1d_wr_paddr    (l1d_wr_paddr),
    .o_l1d_wr_data     (l1d_wr_data),
    .i_l1d_wr_conflict (l1d_wr_conflict)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // full word write of the rs2 value to the table address
  function automatic exp_write_t exp_store(input store_rec_t rec);
    exp_write_t w;
    w.addr = addr_tab[rec.tab_sel];
    w.data = rec.wb_data;
    return w;
  endfunction

  task automatic note_error(input string msg);
    errors++;
    $display("[FAIL] %0t ns: %s", $time, msg);
  endtask

  task automatic check_addr(input stq_addr_t got, input stq_addr_t want, input string what);
    checks++;
    if (got !== want) begin
      note_error($sformatf("%s got %h expected %h", what, got, want));
    end
  endtask

  task automatic check_data(input stq_data_t got, input stq_data_t want, input string what);
    checks++;
    if (got !== want) begin
      note_error($sformatf("%s got %h expected %h", what, got, want));
    end
  endtask

  task automatic check_cmt_id(input stq_cmt_id_t got, input stq_cmt_id_t want,
                              input string what);
    checks++;
    if (got !== want) begin
      note_error($sformatf("%s got id %0d expected %0d", what, got, want));
    end
  endtask

  task automatic check_rnid(input stq_rnid_t got, input stq_rnid_t want, input string what);
    checks++;
    if (got !== want) begin
      note_error($sformatf("%s got r%0d expected r%0d", what, got, want));
    end
  endtask

  task automatic step_wait(inout int guard, input string what);
    @(negedge clk);
    guard++;
    if (guard > WAIT_LIMIT) begin
      $display("timeout after %0d cycles waiting for %s", WAIT_LIMIT, what);
      $display("TEST FAILED");
      $finish;
    end
  endtask

  task automatic dispatch_store(input bit ops_ready, input bit will_write,
                                output store_rec_t rec);
    int guard;
    guard = 0;
    while (disp_full) begin
      step_wait(guard, "room in the store queue");
    end
    rec.cmt_id  = stq_cmt_id_t'(next_cmt);
    rec.rs1     = stq_rnid_t'(next_rnid);
    rec.rs2     = stq_rnid_t'(next_rnid + 1);
    rec.tab_sel = 4'($urandom_range(TAB_SIZE - 1));
    rec.wb_data = $urandom;
    rec.slot    = in_slot;
    next_cmt++;
    next_rnid += 2;
    in_slot++;
    slot_rec[rec.slot]    = rec;
    rs1_woken[rec.slot]   = ops_ready;
    rs2_woken[rec.slot]   = ops_ready;
    issue_count[rec.slot] = 0;
    disp_valid     = 1'b1;
    disp_cmt_id    = rec.cmt_id;
    disp_rs1_rnid  = rec.rs1;
    disp_rs1_ready = ops_ready;
    disp_rs2_rnid  = rec.rs2;
    disp_rs2_ready = ops_ready;
    phy_wr_valid[1] = ops_ready; // ready data rides bus 1 in the dispatch cycle
    phy_wr_rnid[1]  = rec.rs2;
    phy_wr_data[1]  = rec.wb_data;
    if (will_write) begin
      exp_q.push_back(rec);
      commit_q.push_back(rec.cmt_id);
    end
    @(negedge clk);
    disp_valid      = 1'b0;
    phy_wr_valid[1] = 1'b0;
  endtask

  task automatic drive_wb(input int bus, input stq_rnid_t rnid, input stq_data_t data);
    phy_wr_valid[bus] = 1'b1;
    phy_wr_rnid[bus]  = rnid;
    phy_wr_data[bus]  = data;
    @(negedge clk);
    phy_wr_valid[bus] = 1'b0;
  endtask

  task automatic wait_drain();
    int guard;
    guard = 0;
    while (exp_q.size() != 0 || commit_q.size() != 0) begin
      step_wait(guard, "the store queue to drain");
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
    end
  endtask

  // address pipeline, answers one cycle after each issue
  initial begin : ex1_model
    bit         fire;
    stq_index_t idx;
    ex1_valid  = 1'b0;
    ex1_index  = '0;
    ex1_hazard = 1'b0;
    ex1_paddr  = '0;
    forever begin
      @(posedge clk);
      fire = reset_n && issue_valid;
      idx  = issue_index;
      if (fire) begin
        issue_count[idx]++;
        check_rnid(issue_rs1_rnid, slot_rec[idx].rs1, "issue rs1 id");
        if (!rs1_woken[idx]) begin
          note_error($sformatf("entry %0d issued before its rs1 was ready", idx));
        end
      end
      @(negedge clk);
      ex1_valid  = fire;
      ex1_index  = idx;
      ex1_hazard = fire && hazard_armed && (idx == hazard_slot);
      ex1_paddr  = addr_tab[slot_rec[idx].tab_sel];
      if (ex1_hazard) begin
        hazard_armed = 1'b0;
        hazard_hits++;
      end
    end
  end

  initial begin : l1d_model
    l1d_wr_conflict = 1'b0;
    forever begin
      @(negedge clk);
      l1d_wr_conflict = l1d_wr_valid && conflict_en && ($urandom_range(99) < 40);
    end
  end

  // done report is due two edges after a clean ex1 result with rs2 in hand
  initial begin : done_monitor
    bit          pipe_v  [2];
    stq_cmt_id_t pipe_id [2];
    pipe_v[0]  = 1'b0;
    pipe_v[1]  = 1'b0;
    pipe_id[0] = '0;
    pipe_id[1] = '0;
    forever begin
      @(posedge clk);
      if (reset_n && (done_valid !== pipe_v[1])) begin
        note_error($sformatf("done valid %b expected %b", done_valid, pipe_v[1]));
      end
      if (reset_n && done_valid) begin
        if (pipe_v[1]) begin
          check_cmt_id(done_cmt_id, pipe_id[1], "done id");
        end
        done_seen[done_cmt_id] = 1'b1;
      end
      pipe_v[1]  = pipe_v[0];
      pipe_id[1] = pipe_id[0];
      pipe_v[0]  = reset_n && ex1_valid && !ex1_hazard && rs2_woken[ex1_index];
      pipe_id[0] = slot_rec[ex1_index].cmt_id;
    end
  end

  // commits in program order once the done report is in
  initial begin : commit_driver
    commit_valid  = 1'b0;
    commit_cmt_id = '0;
    commit_flush  = 1'b0;
    forever begin
      @(negedge clk);
      commit_valid = 1'b0;
      commit_flush = 1'b0;
      if (auto_commit && commit_q.size() != 0 && done_seen[commit_q[0]]) begin
        commit_valid  = 1'b1;
        commit_cmt_id = commit_q.pop_front();
        commit_flush  = flush_armed && (commit_cmt_id == flush_cmt_id);
        if (commit_flush) begin
          flush_armed = 1'b0;
        end
        done_seen[commit_cmt_id] = 1'b0;
        commits_open++;
      end
    end
  end

  initial begin : write_monitor
    store_rec_t rec;
    exp_write_t want;
    forever begin
      @(posedge clk);
      if (reset_n && l1d_wr_valid && l1d_wr_conflict) begin
        conflict_count++;
      end else if (reset_n && l1d_wr_valid) begin
        if (exp_q.size() == 0 || commits_open == 0) begin
          note_error("L1D write with no committed store left to match");
        end else begin
          rec  = exp_q.pop_front();
          want = exp_store(rec);
          commits_open--;
          check_addr(l1d_wr_paddr, want.addr, "write address");
          check_data(l1d_wr_data, want.data, "write data");
        end
      end
    end
  end

  initial begin : main
    store_rec_t rec;
    store_rec_t late [4];
    int         i;
    int         guard;
    int         err0;
    int         hits0;
    int         conflicts0;
    void'($urandom(61));
    reset_n        = 1'b0;
    disp_valid     = 1'b0;
    disp_cmt_id    = '0;
    disp_rs1_rnid  = '0;
    disp_rs1_ready = 1'b0;
    disp_rs2_rnid  = '0;
    disp_rs2_ready = 1'b0;
    tlb_resolve    = 1'b0;
    for (i = 0; i < `STQ_PHY_WR_NUM; i++) begin
      phy_wr_valid[i] = 1'b0;
      phy_wr_rnid[i]  = '0;
      phy_wr_data[i]  = '0;
    end
    for (i = 0; i < TAB_SIZE; i++) begin
      addr_tab[i] = 32'h8000_0000 + i * 32'h0000_0104;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
    @(negedge clk);
    if (issue_valid || done_valid || l1d_wr_valid || disp_full) begin
      note_error("outputs not idle after reset");
    end

    err0 = errors;
    auto_commit = 1'b0; // hold commits so the queue fills
    for (i = 0; i < 8; i++) begin
      dispatch_store(1'b1, 1'b1, rec);
    end
    if (disp_full !== 1'b1) begin
      note_error("full did not rise after eight dispatches");
    end
    auto_commit = 1'b1;
    wait_drain();
    if (disp_full !== 1'b0) begin
      note_error("full still high after the drain");
    end
    end_test("ordered drain", err0);

    err0 = errors;
    for (i = 0; i < 4; i++) begin
      dispatch_store(1'b0, 1'b1, late[i]);
    end
    repeat (6) @(negedge clk); // nothing may issue yet
    for (i = 0; i < 4; i++) begin
      rs1_woken[late[i].slot] = 1'b1;
      drive_wb(0, late[i].rs1, $urandom);
    end
    for (i = 0; i < 4; i++) begin
      guard = 0;
      while (issue_count[late[i].slot] == 0) begin
        step_wait(guard, "a woken store to issue");
      end
    end
    for (i = 0; i < 4; i++) begin
      rs2_woken[late[i].slot] = 1'b1;
      drive_wb(1, late[i].rs2, late[i].wb_data);
    end
    wait_drain();
    end_test("late operands", err0);

    err0  = errors;
    hits0 = hazard_hits;
    hazard_slot  = (int'(in_slot) + 1) % `STQ_ENTRY_NUM;
    hazard_armed = 1'b1;
    for (i = 0; i < 4; i++) begin
      dispatch_store(1'b1, 1'b1, late[i]);
    end
    guard = 0;
    while (hazard_hits == hits0) begin
      step_wait(guard, "the TLB hazard response");
    end
    repeat (10) @(negedge clk);
    if (issue_count[late[1].slot] != 1) begin
      note_error("hazarded store issued again before the TLB resolve");
    end
    tlb_resolve = 1'b1;
    @(negedge clk);
    tlb_resolve = 1'b0;
    wait_drain();
    end_test("tlb hazard", err0);

    err0 = errors;
    auto_commit = 1'b0; // all eight must be in before the flush
    dispatch_store(1'b1, 1'b1, late[0]);
    dispatch_store(1'b1, 1'b1, late[1]);
    flush_cmt_id = late[1].cmt_id;
    for (i = 0; i < 6; i++) begin
      dispatch_store(1'b0, 1'b0, rec); // never woken, killed by the flush
    end
    flush_armed = 1'b1;
    auto_commit = 1'b1;
    guard = 0;
    while (flush_armed) begin
      step_wait(guard, "the commit flush");
    end
    wait_drain();
    for (i = 0; i < 4; i++) begin
      dispatch_store(1'b1, 1'b1, rec);
    end
    wait_drain();
    end_test("commit flush", err0);

    err0       = errors;
    conflicts0 = conflict_count;
    conflict_en = 1'b1;
    for (i = 0; i < 12; i++) begin
      dispatch_store(1'b1, 1'b1, rec);
    end
    wait_drain();
    conflict_en = 1'b0;
    if (conflict_count == conflicts0) begin
      note_error("no L1D conflicts were raised");
    end
    end_test("l1d conflicts", err0);

    repeat (10) @(negedge clk); // catch stray writes
    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: stq_top.sv
`timescale 1ns/10ps
`include "stq_settings.svh"

module stq_top (
  input  logic                 i_clk,
  input  logic                 i_reset_n,

  input  logic                 i_disp_valid,
  input  stq_pkg::stq_cmt_id_t i_disp_cmt_id,
  input  stq_pkg::stq_rnid_t   i_disp_rs1_rnid,
  input  logic                 i_disp_rs1_ready,
  input  stq_pkg::stq_rnid_t   i_disp_rs2_rnid,
  input  logic                 i_disp_rs2_ready,
  output logic                 o_disp_full,

  input  logic                 i_phy_wr_valid [`STQ_PHY_WR_NUM],
  input  stq_pkg::stq_rnid_t   i_phy_wr_rnid  [`STQ_PHY_WR_NUM],
  input  stq_pkg::stq_data_t   i_phy_wr_data  [`STQ_PHY_WR_NUM],

  output logic                 o_issue_valid,
  output stq_pkg::stq_index_t  o_issue_index,
  output stq_pkg::stq_rnid_t   o_issue_rs1_rnid,

  input  logic                 i_ex1_valid,
  input  stq_pkg::stq_index_t  i_ex1_index,
  input  logic                 i_ex1_hazard,
  input  stq_pkg::stq_addr_t   i_ex1_paddr,
  input  logic                 i_tlb_resolve,

  output logic                 o_done_valid,
  output stq_pkg::stq_cmt_id_t o_done_cmt_id,

  input  logic                 i_commit_valid,
  input  stq_pkg::stq_cmt_id_t i_commit_cmt_id,
  input  logic                 i_commit_flush,

  output logic                 o_l1d_wr_valid,
  output stq_pkg::stq_addr_t   o_l1d_wr_paddr,
  output stq_pkg::stq_data_t   o_l1d_wr_data,
  input  logic                 i_l1d_wr_conflict
);

  import stq_pkg::*;

  localparam int IDX_W = $bits(stq_index_t);

  logic [IDX_W:0]            r_in_ptr;  // msb is the wrap bit
  logic [IDX_W:0]            r_out_ptr;
  stq_index_t                w_in_idx;
  stq_index_t                w_out_idx;
  logic                      w_disp_fire;
  logic                      w_head_free;

  logic [`STQ_ENTRY_NUM-1:0] w_disp_load;
  logic [`STQ_ENTRY_NUM-1:0] w_issue_req;
  logic [`STQ_ENTRY_NUM-1:0] w_picked_oh;
  logic [`STQ_ENTRY_NUM-1:0] w_ex1_hit;
  logic [`STQ_ENTRY_NUM-1:0] w_at_head;
  logic [`STQ_ENTRY_NUM-1:0] w_valid;
  logic [`STQ_ENTRY_NUM-1:0] w_free;

  stq_state_t                w_state   [`STQ_ENTRY_NUM];
  stq_cmt_id_t               w_cmt_id  [`STQ_ENTRY_NUM];
  stq_addr_t                 w_paddr   [`STQ_ENTRY_NUM];
  stq_data_t                 w_data    [`STQ_ENTRY_NUM];
  stq_rnid_t                 w_rs1_rnid[`STQ_ENTRY_NUM];

  assign w_in_idx  = r_in_ptr[IDX_W-1:0];
  assign w_out_idx = r_out_ptr[IDX_W-1:0];

  assign o_disp_full = (r_in_ptr[IDX_W] != r_out_ptr[IDX_W]) & (w_in_idx == w_out_idx);
  assign w_disp_fire = i_disp_valid & !o_disp_full;
  assign w_head_free = w_free[w_out_idx];

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_ptr  <= '0;
      r_out_ptr <= '0;
    end else begin
      if (w_disp_fire) begin
        r_in_ptr <= r_in_ptr + 1'b1;
      end
      if (w_head_free) begin
        r_out_ptr <= r_out_ptr + 1'b1;
      end
    end
  end

  for (genvar k = 0; k < `STQ_ENTRY_NUM; k++) begin : g_entry
    assign w_disp_load[k] = w_disp_fire & (w_in_idx == IDX_W'(k));
    assign w_ex1_hit[k]   = i_ex1_valid & (i_ex1_index == IDX_W'(k));
    assign w_at_head[k]   = (w_out_idx == IDX_W'(k));

    stq_entry entry_i (
      .i_clk             (i_clk),
      .i_reset_n         (i_reset_n),
      .i_disp_load       (w_disp_load[k]),
      .i_disp_cmt_id     (i_disp_cmt_id),
      .i_disp_rs1_rnid   (i_disp_rs1_rnid),
      .i_disp_rs1_ready  (i_disp_rs1_ready),
      .i_disp_rs2_rnid   (i_disp_rs2_rnid),
      .i_disp_rs2_ready  (i_disp_rs2_ready),
      .i_phy_wr_valid    (i_phy_wr_valid),
      .i_phy_wr_rnid     (i_phy_wr_rnid),
      .i_phy_wr_data     (i_phy_wr_data),
      .o_issue_req       (w_issue_req[k]),
      .i_picked          (w_picked_oh[k]),
      .o_rs1_rnid        (w_rs1_rnid[k]),
      .i_ex1_hit         (w_ex1_hit[k]),
      .i_ex1_hazard      (i_ex1_hazard),
      .i_ex1_paddr       (i_ex1_paddr),
      .i_tlb_resolve     (i_tlb_resolve),
      .i_commit_valid    (i_commit_valid),
      .i_commit_cmt_id   (i_commit_cmt_id),
      .i_commit_flush    (i_commit_flush),
      .o_valid           (w_valid[k]),
      .o_state           (w_state[k]),
      .o_cmt_id          (w_cmt_id[k]),
      .o_paddr           (w_paddr[k]),
      .o_data            (w_data[k]),
      .i_at_head         (w_at_head[k]),
      .i_l1d_wr_conflict (i_l1d_wr_conflict),
      .o_free            (w_free[k])
    );
  end

  stq_issue_select issue_select_i (
    .i_req       (w_issue_req),
    .i_out_ptr   (w_out_idx),
    .o_valid     (o_issue_valid),
    .o_index     (o_issue_index),
    .o_picked_oh (w_picked_oh)
  );

  assign o_issue_rs1_rnid = w_rs1_rnid[o_issue_index];

  // one ex1 result per cycle, so at most one entry sits in DONE_EX3
  always_comb begin
    o_done_valid  = 1'b0;
    o_done_cmt_id = '0;
    for (int k = 0; k < `STQ_ENTRY_NUM; k++) begin
      if (w_valid[k] && (w_state[k] == DONE_EX3)) begin
        o_done_valid  = 1'b1;
        o_done_cmt_id = w_cmt_id[k];
      end
    end
  end

  // only the head drains
  assign o_l1d_wr_valid = w_valid[w_out_idx] & (w_state[w_out_idx] == L1D_UPDATE);
  assign o_l1d_wr_paddr = w_paddr[w_out_idx];
  assign o_l1d_wr_data  = w_data[w_out_idx];

endmodule

// File: stq_issue_select.sv
`timescale 1ns/10ps
`include "stq_settings.svh"

module stq_issue_select (
  input  logic [`STQ_ENTRY_NUM-1:0] i_req,
  input  stq_pkg::stq_index_t       i_out_ptr,

  output logic                      o_valid,
  output stq_pkg::stq_index_t       o_index,
  output logic [`STQ_ENTRY_NUM-1:0] o_picked_oh
);

  import stq_pkg::*;

  logic [2*`STQ_ENTRY_NUM-1:0] w_req_dbl;
  logic [`STQ_ENTRY_NUM-1:0]   w_req_rot;
  stq_index_t                  w_rot_index;

  // bit 0 of the rotated vector is the oldest entry
  assign w_req_dbl = {i_req, i_req} >> i_out_ptr;
  assign w_req_rot = w_req_dbl[`STQ_ENTRY_NUM-1:0];

  always_comb begin
    w_rot_index = '0;
    for (int k = `STQ_ENTRY_NUM - 1; k >= 0; k--) begin
      if (w_req_rot[k]) begin
        w_rot_index = stq_index_t'(k);
      end
    end
  end

  assign o_valid = |i_req;
  assign o_index = w_rot_index + i_out_ptr; // wraps with the index width

  assign o_picked_oh = o_valid ? ({{(`STQ_ENTRY_NUM-1){1'b0}}, 1'b1} << o_index) : '0;

endmodule

// File: stq_entry.sv
`timescale 1ns/10ps
`include "stq_settings.svh"

module stq_entry (
  input  logic                 i_clk,
  input  logic                 i_reset_n,

  input  logic                 i_disp_load,
  input  stq_pkg::stq_cmt_id_t i_disp_cmt_id,
  input  stq_pkg::stq_rnid_t   i_disp_rs1_rnid,
  input  logic                 i_disp_rs1_ready,
  input  stq_pkg::stq_rnid_t   i_disp_rs2_rnid,
  input  logic                 i_disp_rs2_ready,

  input  logic                 i_phy_wr_valid [`STQ_PHY_WR_NUM],
  input  stq_pkg::stq_rnid_t   i_phy_wr_rnid  [`STQ_PHY_WR_NUM],
  input  stq_pkg::stq_data_t   i_phy_wr_data  [`STQ_PHY_WR_NUM],

  output logic                 o_issue_req,
  input  logic                 i_picked,
  output stq_pkg::stq_rnid_t   o_rs1_rnid,

  input  logic                 i_ex1_hit,
  input  logic                 i_ex1_hazard,
  input  stq_pkg::stq_addr_t   i_ex1_paddr,
  input  logic                 i_tlb_resolve,

  input  logic                 i_commit_valid,
  input  stq_pkg::stq_cmt_id_t i_commit_cmt_id,
  input  logic                 i_commit_flush,

  output logic                 o_valid,
  output stq_pkg::stq_state_t  o_state,
  output stq_pkg::stq_cmt_id_t o_cmt_id,
  output stq_pkg::stq_addr_t   o_paddr,
  output stq_pkg::stq_data_t   o_data,

  input  logic                 i_at_head,
  input  logic                 i_l1d_wr_conflict,
  output logic                 o_free
);

  import stq_pkg::*;

  stq_state_t  r_state;
  stq_state_t  w_state_next;
  logic        r_valid;
  logic        r_rs1_ready;
  logic        r_rs2_ready;

  stq_cmt_id_t r_cmt_id;
  stq_rnid_t   r_rs1_rnid;
  stq_rnid_t   r_rs2_rnid;
  stq_addr_t   r_paddr;
  stq_data_t   r_rs2_data;

  stq_rnid_t   w_rs1_rnid;
  stq_rnid_t   w_rs2_rnid;
  logic        w_rs1_hit;
  logic        w_rs2_hit;
  stq_data_t   w_rs2_wb_data;
  logic        w_rs1_ready_next;
  logic        w_rs2_ready_next;
  logic        w_rs2_capture;
  logic        w_pre_commit;
  logic        w_cmt_match;
  logic        w_flush;

  // look at the incoming ids in the dispatch cycle so a same-cycle wakeup is kept
  assign w_rs1_rnid = i_disp_load ? i_disp_rs1_rnid : r_rs1_rnid;
  assign w_rs2_rnid = i_disp_load ? i_disp_rs2_rnid : r_rs2_rnid;

  stq_operand_match rs1_match_i (
    .i_rnid         (w_rs1_rnid),
    .i_phy_wr_valid (i_phy_wr_valid),
    .i_phy_wr_rnid  (i_phy_wr_rnid),
    .i_phy_wr_data  (i_phy_wr_data),
    .o_hit          (w_rs1_hit),
    .o_data         ()
  );

  stq_operand_match rs2_match_i (
    .i_rnid         (w_rs2_rnid),
    .i_phy_wr_valid (i_phy_wr_valid),
    .i_phy_wr_rnid  (i_phy_wr_rnid),
    .i_phy_wr_data  (i_phy_wr_data),
    .o_hit          (w_rs2_hit),
    .o_data         (w_rs2_wb_data)
  );

  assign w_rs1_ready_next = (i_disp_load ? i_disp_rs1_ready : r_rs1_ready) | w_rs1_hit;
  assign w_rs2_ready_next = (i_disp_load ? i_disp_rs2_ready : r_rs2_ready) | w_rs2_hit;

  // store data only ever comes from the write-back buses
  assign w_rs2_capture = w_rs2_hit & (i_disp_load | !r_rs2_ready);

  assign w_pre_commit = r_valid &
                        (r_state != INIT) &
                        (r_state != COMMIT) &
                        (r_state != L1D_UPDATE) &
                        (r_state != DEAD);

  assign w_cmt_match = i_commit_valid &
                       (r_state == WAIT_COMMIT) &
                       (i_commit_cmt_id == r_cmt_id);

  // the committing store itself survives its own flush
  assign w_flush = i_commit_flush & w_pre_commit & !w_cmt_match;

  assign o_issue_req = (r_state == ISSUE_WAIT) & r_rs1_ready & !i_commit_flush;

  assign o_free = ((r_state == L1D_UPDATE) & !i_l1d_wr_conflict) |
                  ((r_state == DEAD) & i_at_head);

  always_comb begin
    w_state_next = r_state;
    if (w_flush) begin
      w_state_next = DEAD;
    end else begin
      case (r_state)
        INIT: begin
          if (i_disp_load) begin
            w_state_next = ISSUE_WAIT;
          end
        end
        ISSUE_WAIT: begin
          if (o_issue_req & i_picked) begin
            w_state_next = ISSUED;
          end
        end
        ISSUED: begin
          if (i_ex1_hit) begin
            if (i_ex1_hazard) begin
              w_state_next = TLB_HAZ;
            end else if (!w_rs2_ready_next) begin
              w_state_next = WAIT_ST_DATA;
            end else begin
              w_state_next = DONE_EX2;
            end
          end
        end
        TLB_HAZ: begin
          if (i_tlb_resolve) begin
            w_state_next = ISSUE_WAIT; // re-issue
          end
        end
        WAIT_ST_DATA: begin
          if (r_rs2_ready) begin
            w_state_next = ISSUE_WAIT;
          end
        end
        DONE_EX2:    w_state_next = DONE_EX3;
        DONE_EX3:    w_state_next = WAIT_COMMIT;
        WAIT_COMMIT: begin
          if (w_cmt_match) begin
            w_state_next = COMMIT;
          end
        end
        COMMIT: begin
          if (i_at_head) begin
            w_state_next = L1D_UPDATE;
          end
        end
        L1D_UPDATE:  w_state_next = i_l1d_wr_conflict ? COMMIT : INIT; // replay on conflict
        DEAD: begin
          if (i_at_head) begin
            w_state_next = INIT;
          end
        end
        default:     w_state_next = INIT;
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state     <= INIT;
      r_valid     <= 1'b0;
      r_rs1_ready <= 1'b0;
      r_rs2_ready <= 1'b0;
    end else begin
      r_state     <= w_state_next;
      r_rs1_ready <= w_rs1_ready_next;
      r_rs2_ready <= w_rs2_ready_next;
      if (i_disp_load) begin
        r_valid <= 1'b1;
      end else if (o_free) begin
        r_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_disp_load) begin
      r_cmt_id   <= i_disp_cmt_id;
      r_rs1_rnid <= i_disp_rs1_rnid;
      r_rs2_rnid <= i_disp_rs2_rnid;
    end
    if ((r_state == ISSUED) && i_ex1_hit && !i_ex1_hazard) begin
      r_paddr <= i_ex1_paddr;
    end
    if (w_rs2_capture) begin
      r_rs2_data <= w_rs2_wb_data;
    end
  end

  assign o_valid    = r_valid;
  assign o_state    = r_state;
  assign o_cmt_id   = r_cmt_id;
  assign o_paddr    = r_paddr;
  assign o_data     = r_rs2_data;
  assign o_rs1_rnid = r_rs1_rnid;

endmodule

// File: stq_operand_match.sv
`timescale 1ns/10ps
`include "stq_settings.svh"

module stq_operand_match (
  input  stq_pkg::stq_rnid_t i_rnid,

  input  logic               i_phy_wr_valid [`STQ_PHY_WR_NUM],
  input  stq_pkg::stq_rnid_t i_phy_wr_rnid  [`STQ_PHY_WR_NUM],
  input  stq_pkg::stq_data_t i_phy_wr_data  [`STQ_PHY_WR_NUM],

  output logic               o_hit,
  output stq_pkg::stq_data_t o_data
);

  logic [`STQ_PHY_WR_NUM-1:0] w_bus_hit;

  // at most one bus carries a given rnid per cycle, so an and-or mux is enough
  always_comb begin
    o_data = '0;
    for (int b = 0; b < `STQ_PHY_WR_NUM; b++) begin
      w_bus_hit[b] = i_phy_wr_valid[b] & (i_phy_wr_rnid[b] == i_rnid);
      o_data       = o_data | ({`STQ_XLEN{w_bus_hit[b]}} & i_phy_wr_data[b]);
    end
  end

  assign o_hit = |w_bus_hit;

endmodule

// File: stq_pkg.sv
`include "stq_settings.svh"

package stq_pkg;

  typedef logic [$clog2(`STQ_ENTRY_NUM)-1:0] stq_index_t;

  typedef logic [`STQ_RNID_W-1:0]   stq_rnid_t;
  typedef logic [`STQ_CMT_ID_W-1:0] stq_cmt_id_t;
  typedef logic [`STQ_PADDR_W-1:0]  stq_addr_t;
  typedef logic [`STQ_XLEN-1:0]     stq_data_t;

  // per-entry lifecycle
  typedef enum logic [3:0] {
    INIT,
    ISSUE_WAIT,
    ISSUED,
    TLB_HAZ,       // waiting for tlb resolve
    WAIT_ST_DATA,  // address done, rs2 still missing
    DONE_EX2,
    DONE_EX3,
    WAIT_COMMIT,
    COMMIT,
    L1D_UPDATE,
    DEAD
  } stq_state_t;

endpackage

// File: stq_settings.svh
`ifndef STQ_SETTINGS_SVH
`define STQ_SETTINGS_SVH

// queue geometry
`define STQ_ENTRY_NUM 8

// register and commit ids
`define STQ_RNID_W   6
`define STQ_CMT_ID_W 6

// payload widths
`define STQ_XLEN    32
`define STQ_PADDR_W 32

// write-back buses seen by every entry
`define STQ_PHY_WR_NUM 2

`endif
